//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and register file sizes
`define RV_XLEN       32
`define RV_NUM_REGS   32
`define RV_REG_IDX_W  5

`define RV_RESET_PC   32'h0000_0000
`define RV_PC_STEP    32'd4        // One 4-byte instruction

// Major opcodes, insn[6:0]
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_REG_IMM  7'b0010011
`define RV_OP_REG_REG  7'b0110011
`define RV_OP_MISC_MEM 7'b0001111  // FENCE
`define RV_OP_SYSTEM   7'b1110011  // ECALL

// funct3 of the integer ALU group
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL_SRA  3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000  // Selects SUB and SRA/SRAI

`endif

//--- src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // Registers, PC and immediates
  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;  // x0 to x31

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Values match the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    WB_ALU,     // ALU result
    WB_PC4,     // Link address for JAL and JALR
    WB_IMM,     // LUI
    WB_PC_IMM   // AUIPC
  } wb_sel_e;

endpackage

//--- src/reg_file.sv
`timescale 1ns/1ns

module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     we,
  input  word_t    wdata,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

  word_t regs [NUM_REGS];

  // Reset wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 is never written
      regs[rd] <= wdata;
    end
  end

  // Combinational reads, x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/insn_decode.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module insn_decode
  import rv_pkg::*;
(
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_e  alu_op,
  output logic     use_imm,
  output logic     reg_we,
  output wb_sel_e  wb_sel,
  output logic     is_branch,
  output logic     is_jal,
  output logic     is_jalr,
  output br_cond_e br_cond,
  output logic     halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // Sign-extended immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // alt picks SUB or SRA in the shared funct3 slots
  function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      `RV_F3_ADD_SUB: f3_to_op = alt ? ALU_SUB : ALU_ADD;
      `RV_F3_SLL:     f3_to_op = ALU_SLL;
      `RV_F3_SLT:     f3_to_op = ALU_SLT;
      `RV_F3_SLTU:    f3_to_op = ALU_SLTU;
      `RV_F3_XOR:     f3_to_op = ALU_XOR;
      `RV_F3_SRL_SRA: f3_to_op = alt ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:      f3_to_op = ALU_OR;
      default:        f3_to_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    wb_sel    = WB_ALU;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    br_cond   = BR_EQ;
    halt      = 1'b0;

    case (opcode)
      `RV_OP_LUI: begin
        imm    = imm_u;
        reg_we = 1'b1;
        wb_sel = WB_IMM;
      end
      `RV_OP_AUIPC: begin
        imm    = imm_u;
        reg_we = 1'b1;
        wb_sel = WB_PC_IMM;
      end
      `RV_OP_JAL: begin
        imm    = imm_j;
        reg_we = 1'b1;
        wb_sel = WB_PC4;
        is_jal = 1'b1;
      end
      `RV_OP_JALR: begin
        reg_we  = (funct3 == 3'b000);
        wb_sel  = WB_PC4;
        is_jalr = (funct3 == 3'b000);
      end
      `RV_OP_BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);  // Two holes in funct3
        br_cond   = br_cond_e'(funct3);
      end
      `RV_OP_REG_IMM: begin
        use_imm = 1'b1;
        alu_op  = f3_to_op(funct3, funct3 == `RV_F3_SRL_SRA && funct7 == `RV_F7_ALT);
        // Shift immediates restrict the upper bits, the rest take any imm
        reg_we  = (funct3 != `RV_F3_SLL && funct3 != `RV_F3_SRL_SRA) ||
                  funct7 == `RV_F7_BASE ||
                  (funct3 == `RV_F3_SRL_SRA && funct7 == `RV_F7_ALT);
      end
      `RV_OP_REG_REG: begin
        alu_op = f3_to_op(funct3, funct7 == `RV_F7_ALT);
        reg_we = funct7 == `RV_F7_BASE ||
                 (funct7 == `RV_F7_ALT &&
                  (funct3 == `RV_F3_ADD_SUB || funct3 == `RV_F3_SRL_SRA));
      end
      `RV_OP_MISC_MEM: begin
        reg_we = 1'b0;                       // FENCE is a no-op here
      end
      `RV_OP_SYSTEM: begin
        halt = (insn[31:7] == '0);           // ECALL only
      end
      default: begin
        reg_we = 1'b0;
      end
    endcase
  end

endmodule

//--- src/alu.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module alu
  import rv_pkg::*;
(
  input  alu_op_e alu_op,
  input  word_t   a,
  input  word_t   b_reg,
  input  word_t   imm,
  input  logic    use_imm,
  output word_t   result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  word_t              b;
  logic [SHAMT_W-1:0] shamt;

  assign b     = use_imm ? imm : b_reg;  // Register or immediate form
  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SLT: begin
        result = word_t'($signed(a) < $signed(b));
      end
      ALU_SLTU: begin
        result = word_t'(a < b);
      end
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> shamt;
      ALU_SRA: begin
        result = $signed(a) >>> shamt;   // Keeps the sign bit
      end
      ALU_OR:  result = a | b;
      ALU_AND: result = a & b;
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- src/pc_unit.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module pc_unit
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     halt,
  input  logic     is_branch,
  input  logic     is_jal,
  input  logic     is_jalr,
  input  br_cond_e br_cond,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    imm,
  output word_t    pc,
  output word_t    pc_plus4
);

  logic  cond_true;
  word_t pc_next;

  // Branch comparison on the two register operands
  always_comb begin
    case (br_cond)
      BR_EQ:   cond_true = (rs1_data == rs2_data);
      BR_NE:   cond_true = (rs1_data != rs2_data);
      BR_LT:   cond_true = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   cond_true = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  cond_true = (rs1_data < rs2_data);
      BR_GEU:  cond_true = (rs1_data >= rs2_data);
      default: cond_true = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + `RV_PC_STEP;

  always_comb begin
    if (halt) begin
      pc_next = pc;                               // Stay on the ECALL
    end else if (is_jalr) begin
      pc_next = (rs1_data + imm) & ~word_t'(1);
    end else if (is_jal || (is_branch && cond_true)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    insn,
  output word_t    pc,
  output logic     halt,
  output logic     wb_en,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_e  alu_op;
  logic     use_imm;
  logic     reg_we;
  wb_sel_e  wb_sel;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  br_cond_e br_cond;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  word_t    pc_plus4;
  word_t    wdata;

  insn_decode i_decode (
    .insn, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .reg_we, .wb_sel,
    .is_branch, .is_jal, .is_jalr, .br_cond, .halt
  );

  reg_file i_regs (
    .clk, .rst, .rs1, .rs2, .rd,
    .we(reg_we), .wdata, .rs1_data, .rs2_data
  );

  alu i_alu (
    .alu_op, .a(rs1_data), .b_reg(rs2_data), .imm, .use_imm, .result(alu_result)
  );

  pc_unit i_pc (
    .clk, .rst, .halt, .is_branch, .is_jal, .is_jalr, .br_cond,
    .rs1_data, .rs2_data, .imm, .pc, .pc_plus4
  );

  // Write-back source select
  always_comb begin
    case (wb_sel)
      WB_PC4:    wdata = pc_plus4;
      WB_IMM:    wdata = imm;
      WB_PC_IMM: wdata = pc + imm;  // AUIPC
      default:   wdata = alu_result;
    endcase
  end

  // Trace shows exactly what the register file is given
  assign wb_en   = reg_we;
  assign wb_rd   = rd;
  assign wb_data = wdata;

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Power-on reset, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- verif/rv_core_chk.sv
`timescale 1ns/1ns

module rv_core_chk
  import rv_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input word_t pc,
  input logic  halt,
  input logic  wb_en
);

  int fail_cnt = 0;  // Number of failed assertions

  // Instructions are 4 bytes and always aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc %h is not word aligned", pc);
      fail_cnt++;
    end

  a_halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else begin
      $error("pc moved in the cycle after halt");
      fail_cnt++;
    end

  a_no_write_on_halt: assert property (@(posedge clk) !(wb_en && halt))
    else begin
      $error("register write together with halt");
      fail_cnt++;
    end

  // Reset drives an all-zero word, which must not write
  a_no_write_in_reset: assert property (@(posedge clk) rst |-> !wb_en)
    else begin
      $error("register write while in reset");
      fail_cnt++;
    end

endmodule

bind rv_core rv_core_chk i_chk (.clk, .rst, .pc, .halt, .wb_en);

//--- verif/tb_rv_core.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module tb_rv_core
  import rv_pkg::*;
();

  localparam int MAX_TESTS = 8;
  localparam int MAX_PROG  = 32;
  localparam int TIMEOUT   = 200;                     // Cycles to reach ECALL
  localparam word_t ECALL  = {25'b0, `RV_OP_SYSTEM};

  logic     clk;
  logic     por;
  logic     tb_rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // Test table with program words, expected trace and final pc
  string    test_name [MAX_TESTS];
  bit       linear    [MAX_TESTS];                    // Straight-line, pc steps by 4
  word_t    prog      [MAX_TESTS][MAX_PROG];
  int       prog_len  [MAX_TESTS];
  reg_idx_t exp_rd    [MAX_TESTS][MAX_PROG];
  word_t    exp_data  [MAX_TESTS][MAX_PROG];
  int       exp_cnt   [MAX_TESTS];
  word_t    exp_pc    [MAX_TESTS];
  int       nt;
  int       errs;
  word_t    lcg_state;

  tb_clk_gen i_clk_gen (.clk, .rst(por));

  rv_core i_dut (
    .clk, .rst(por | tb_rst), .insn, .pc, .halt, .wb_en, .wb_rd, .wb_data
  );

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG_REG};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  // RV32I integer result, selected by funct3 and the alternate funct7 bit
  function automatic word_t alu_ref(input int f3, input bit alt, input word_t a,
                                    input word_t b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return (a < b) ? 32'd1 : 32'd0;
      4: return a ^ b;
      5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit taken_ref(input int f3, input word_t a, input word_t b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t fetch(input int t, input word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len[t]) begin
      return prog[t][idx];
    end
    return ECALL;                                     // Past the end of the program
  endfunction

  function automatic word_t here();
    return word_t'(4 * prog_len[nt]);
  endfunction

  task automatic begin_test(input string name, input bit lin);
    test_name[nt] = name;
    linear[nt]    = lin;
    prog_len[nt]  = 0;
    exp_cnt[nt]   = 0;
  endtask

  task automatic emit(input word_t w);
    prog[nt][prog_len[nt]] = w;
    prog_len[nt]++;
  endtask

  task automatic expect_wb(input reg_idx_t rd, input word_t data);
    exp_rd[nt][exp_cnt[nt]]   = rd;
    exp_data[nt][exp_cnt[nt]] = data;
    exp_cnt[nt]++;
  endtask

  task automatic end_test();
    exp_pc[nt] = here();                              // Core parks on this ECALL
    emit(ECALL);
    nt++;
  endtask

  // LUI then ADDI, upper part rounded for the signed low part
  task automatic load_const(input reg_idx_t rd, input word_t v);
    word_t upper;
    upper = (v + 32'h800) & 32'hFFFF_F000;
    emit({upper[31:12], rd, `RV_OP_LUI});
    expect_wb(rd, upper);
    emit(enc_i(v[11:0], rd, 3'd0, rd, `RV_OP_REG_IMM));
    expect_wb(rd, v);
  endtask

  task automatic build_table();
    word_t       a;
    word_t       b;
    word_t       p;
    logic [11:0] imm;
    int          br_f3 [6];
    bit          rev;
    reg_idx_t    r1;
    reg_idx_t    r2;
    br_f3 = '{0, 1, 4, 5, 6, 7};
    nt = 0;

    begin_test("reg_imm", 1'b1);
    a = lcg_next() | 32'h8000_0000;                   // Negative, so SRAI shows the sign
    load_const(5'd1, a);
    b = lcg_next() & 32'hFFFF_F000;
    emit({b[31:12], 5'd2, `RV_OP_LUI});
    expect_wb(5'd2, b);
    p = here();
    emit({b[31:12], 5'd3, `RV_OP_AUIPC});
    expect_wb(5'd3, p + b);
    for (int f3 = 0; f3 < 8; f3++) begin
      b = lcg_next();
      imm = (f3 == 1 || f3 == 5) ? {7'b0, b[4:0]} : b[11:0];
      emit(enc_i(imm, 5'd1, 3'(f3), reg_idx_t'(10 + f3), `RV_OP_REG_IMM));
      expect_wb(reg_idx_t'(10 + f3), alu_ref(f3, 1'b0, a, sext12(imm)));
    end
    imm = {`RV_F7_ALT, (b[9:5] | 5'd1)};              // SRAI by at least one bit
    emit(enc_i(imm, 5'd1, 3'd5, 5'd18, `RV_OP_REG_IMM));
    expect_wb(5'd18, alu_ref(5, 1'b1, a, sext12(imm)));
    end_test();

    begin_test("reg_reg", 1'b1);
    a = lcg_next() | 32'h8000_0000;                   // Signed and unsigned order differ
    b = (lcg_next() & 32'h7FFF_FFFF) | 32'h1;         // Odd, so every shift moves bits
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int f3 = 0; f3 < 10; f3++) begin
      // Last two passes are SUB and SRA
      emit(enc_r((f3 > 7) ? `RV_F7_ALT : `RV_F7_BASE, 5'd2, 5'd1,
                 (f3 == 8) ? 3'd0 : (f3 == 9) ? 3'd5 : 3'(f3), reg_idx_t'(10 + f3)));
      expect_wb(reg_idx_t'(10 + f3),
                alu_ref((f3 == 8) ? 0 : (f3 == 9) ? 5 : f3, f3 > 7, a, b));
    end
    emit(enc_r(`RV_F7_BASE, 5'd2, 5'd1, 3'd0, 5'd0)); // x0 write still traced
    expect_wb(5'd0, a + b);
    emit(enc_r(`RV_F7_BASE, 5'd0, 5'd0, 3'd0, 5'd5));
    expect_wb(5'd5, 32'd0);
    end_test();

    begin_test("branch", 1'b0);
    a = lcg_next() | 32'h8000_0000;
    b = lcg_next() & 32'h7FFF_FFFF;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int i = 0; i < 12; i++) begin
      // Even entries compare x1 with x2
      // Odd ones compare x1 with itself for EQ and NE, else x2 with x1
      rev = (i % 2 == 1) && (br_f3[i / 2] > 1);
      r1  = rev ? 5'd2 : 5'd1;
      r2  = (i % 2 == 0) ? 5'd2 : 5'd1;
      emit(enc_b(13'd8, r2, r1, 3'(br_f3[i / 2])));
      emit(enc_i(12'(i + 1), 5'd0, 3'd0, 5'd7, `RV_OP_REG_IMM));
      if (!taken_ref(br_f3[i / 2], rev ? b : a, (i % 2 == 0) ? b : a)) begin
        expect_wb(5'd7, word_t'(i + 1));
      end
    end
    end_test();

    begin_test("jump", 1'b0);
    emit(enc_j(21'd8, 5'd1));
    expect_wb(5'd1, 32'd4);
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, `RV_OP_REG_IMM));  // Jumped over
    p = here();
    emit(enc_i(12'(p + 13), 5'd0, 3'd0, 5'd5, `RV_OP_REG_IMM));
    expect_wb(5'd5, p + 13);                          // Odd target, JALR clears bit 0
    emit(enc_i(12'd0, 5'd5, 3'd0, 5'd6, `RV_OP_JALR));
    expect_wb(5'd6, p + 8);
    emit(enc_i(12'd2, 5'd0, 3'd0, 5'd7, `RV_OP_REG_IMM));
    end_test();

    begin_test("misc", 1'b1);
    emit(enc_i(12'h0FF, 5'd0, 3'd0, 5'd0, `RV_OP_MISC_MEM));  // FENCE
    emit(32'hFFFF_FFFF);
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, `RV_OP_REG_IMM));
    expect_wb(5'd1, 32'd5);
    end_test();
  endtask

  // Instruction memory answers the new pc a small delay after the edge
  task automatic step(input int t);
    @(posedge clk);
    #1;
    insn = fetch(t, pc);
    #10;
  endtask

  task automatic run_test(input int t);
    int    k;
    int    cyc;
    bit    done;
    word_t hold_pc;
    errs = 0;
    k = 0;
    cyc = 0;
    done = 1'b0;
    tb_rst = 1'b1;
    insn = '0;
    repeat (5) @(posedge clk);
    #1;
    tb_rst = 1'b0;
    insn = fetch(t, pc);
    #10;
    while (!done && cyc < TIMEOUT) begin
      if ((linear[t] || cyc == 0) && pc !== word_t'(4 * cyc)) begin
        $display("[ERROR] %s pc in cycle %0d: expected %h, actual %h",
                 test_name[t], cyc, word_t'(4 * cyc), pc);
        errs++;
      end
      if (wb_en && k >= exp_cnt[t]) begin
        $display("%s: unexpected register write to x%0d", test_name[t], wb_rd);
        errs++;
      end else if (wb_en && (wb_rd !== exp_rd[t][k] || wb_data !== exp_data[t][k])) begin
        $display("[ERROR] %s write %0d: expected x%0d=%h, actual x%0d=%h", test_name[t],
                 k, exp_rd[t][k], exp_data[t][k], wb_rd, wb_data);
        errs++;
      end
      k += int'(wb_en);
      if (halt) begin
        done = 1'b1;
      end else begin
        step(t);
        cyc++;
      end
    end
    if (!done) begin
      $display("%s: no ECALL reached within %0d cycles", test_name[t], TIMEOUT);
      errs++;
    end else begin
      if (pc !== exp_pc[t]) begin
        $display("[ERROR] %s final pc: expected %h, actual %h", test_name[t], exp_pc[t], pc);
        errs++;
      end
      if (k != exp_cnt[t]) begin
        $display("[ERROR] %s write count: expected %0d, actual %0d",
                 test_name[t], exp_cnt[t], k);
        errs++;
      end
      hold_pc = pc;
      for (int i = 0; i < 3; i++) begin
        step(t);
        if (pc !== hold_pc || wb_en !== 1'b0 || halt !== 1'b1) begin
          $display("%s: core left the halt state at pc %h", test_name[t], hold_pc);
          errs++;
        end
      end
    end
    $display("test %s %s (%0d errors)", test_name[t], (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial begin
    int passed;
    int failed;
    passed = 0;
    failed = 0;
    tb_rst = 1'b1;
    insn = '0;
    lcg_state = 32'd59113;
    build_table();
    for (int t = 0; t < nt; t++) begin
      run_test(t);
      if (errs == 0) begin
        passed++;
      end else begin
        failed++;
      end
    end
    $display("%0d tests passed, %0d tests failed, %0d assertion failures",
             passed, failed, i_dut.i_chk.fail_cnt);
    if (failed == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/rv_pkg.sv
src/reg_file.sv
src/insn_decode.sv
src/alu.sv
src/pc_unit.sv
src/rv_core.sv
verif/tb_clk_gen.sv
verif/rv_core_chk.sv
verif/tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := verilog.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
